// File: dv/fetch_tests.txt
# W addr data | R addr expected | T test name
# F rs rob rat hazard branch target enable fetch_addr valid1 valid2 class1 target1 class2 target2
T load_image
W 0 00500093003100B3
W 8 0000A2830050A423
W 10 00208863FE209CE3
W 18 020000EF0000000B
W 20 003100B300500093
T read_back
R 0 00500093003100B3
R 8 0000A2830050A423
R 10 00208863FE209CE3
R 18 020000EF0000000B
R 20 003100B300500093
T sequential
F 0 0 0 0 0 0 1 0 1 1 0 4 0 8
F 0 0 0 0 0 0 1 8 1 1 1 c 2 10
F 0 0 0 0 0 0 1 10 1 1 3 20 3 c
F 0 0 0 0 0 0 1 18 1 1 4 38 7 20
T stall_hold
F 1 0 0 0 0 0 1 20 0 0 0 0 0 0
F 0 1 0 0 0 0 1 20 0 0 0 0 0 0
F 0 0 1 0 0 0 1 20 0 0 0 0 0 0
F 0 0 0 0 0 0 0 20 0 0 0 0 0 0
F 0 0 0 1 0 0 1 20 0 0 0 0 0 0
F 0 0 0 0 0 0 1 20 1 1 0 24 0 28
T branch_over_stall
F 1 0 0 0 1 10 1 28 0 0 0 0 0 0
F 0 0 0 0 0 0 1 10 1 1 3 20 3 c
F 0 0 0 0 1 8 1 18 0 0 0 0 0 0
F 0 0 0 0 0 0 1 8 1 1 1 c 2 10
F 0 1 0 0 1 0 1 10 0 0 0 0 0 0
F 0 0 0 0 0 0 1 0 1 1 0 4 0 8
T out_of_range
F 0 0 0 0 1 800 1 8 0 0 0 0 0 0
F 0 0 0 0 0 0 1 800 0 0 0 0 0 0
F 0 0 0 0 0 0 1 800 0 0 0 0 0 0
F 0 0 0 0 1 18 1 800 0 0 0 0 0 0
F 0 0 0 0 0 0 1 18 1 1 4 38 7 20

// File: fetch.f
common/isa_pkg.sv
common/fetch_pkg.sv
hw/fetch/fetch_pc.sv
hw/fetch/predecode.sv
hw/shared_memory.sv
hw/fetch_top.sv
dv/fetch_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the fetch testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns \
	--top-module fetch_tb --Mdir obj_dir -o fetch_sim \
	-f fetch.f

./obj_dir/fetch_sim > sim.log
cat sim.log

if grep -qx "Regression passed" sim.log; then
	echo "simulation clean"
	exit 0
else
	echo "simulation reported errors, see sim.log"
	exit 1
fi

// File: dv/fetch_tb.sv
/*
 * fetch subsystem testbench
 */

`timescale 1ns/1ns

module fetch_tb
	import fetch_pkg::*;
();

	logic        clock;
	logic        reset;
	stall_t      stalls;
	logic        branch_taken;
	logic [63:0] branch_target;
	logic        fetch_enable;
	data_req_t   data_req;
	logic [63:0] data_rdata;
	logic [63:0] fetch_addr;
	pair_info_t  pair_info;

	int              errors;		// over the whole run
	int              checks;
	int              tests_run;
	int              test_errors;	// inside the current test
	logic            in_test;
	logic [8*32-1:0] test_name;

	fetch_top #(
		.mem_words (256)
	) i_dut (
		.clock         (clock),
		.reset         (reset),
		.stalls        (stalls),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.fetch_enable  (fetch_enable),
		.data_req      (data_req),
		.data_rdata    (data_rdata),
		.fetch_addr    (fetch_addr),
		.pair_info     (pair_info)
	);

	initial
		clock = 1'b0;
	always #10 clock = ~clock;	// 20 ns period

	// reset for 5 cycles, released just after an edge
	initial
	begin
		reset = 1'b1;
		repeat (5) @(posedge clock);
		#2 reset = 1'b0;
	end

	//////////////////////////////////////////////////
	// checking and reporting
	//////////////////////////////////////////////////
	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		checks++;
		if (actual !== expected)
		begin
			$display("FAILED at %0t ns: %0s, got %h expected %h", $time, what, actual, expected);
			errors++;
			test_errors++;
		end
	endtask

	task automatic close_test();
		if (in_test)
		begin
			if (test_errors == 0)
				$display("test %0s: ok", test_name);
			else
				$display("test %0s: %0d errors", test_name, test_errors);
		end
	endtask

	//////////////////////////////////////////////////
	// one step per line, inputs change 2 ns after the edge
	//////////////////////////////////////////////////
	task automatic write_word(input logic [63:0] addr, input logic [63:0] wdata);
		stalls        = '0;
		branch_taken  = 1'b0;
		fetch_enable  = 1'b0;	// fetch idles while the image loads
		data_req      = '{valid: 1'b1, write: 1'b1, addr: addr, wdata: wdata};
		@(posedge clock);
		#2;
	endtask

	task automatic read_word(input logic [63:0] addr, input logic [63:0] expected);
		fetch_enable = 1'b0;
		data_req     = '{valid: 1'b1, write: 1'b0, addr: addr, wdata: 64'd0};
		#8;
		check_value(data_rdata, expected, "data_rdata");	// combinational read
		@(posedge clock);
		#2;
	endtask

	task automatic fetch_step(input logic [63:0] f [14]);
		stalls.rs      = f[0][0];
		stalls.rob     = f[1][0];
		stalls.rat     = f[2][0];
		data_req       = '0;
		data_req.valid = f[3][0];	// read of word 0 takes the port
		branch_taken   = f[4][0];
		branch_target  = f[5];
		fetch_enable   = f[6][0];
		#8;
		check_value(fetch_addr, f[7], "fetch_addr");
		@(posedge clock);
		#1;	// pair_info settles from registers
		check_value(64'(pair_info.slot1.valid), f[8], "slot1 valid");
		check_value(64'(pair_info.slot2.valid), f[9], "slot2 valid");
		if (f[8][0])
		begin
			check_value(pair_info.slot1.pc, f[7], "slot1 pc");
			check_value(64'(pair_info.slot1.op_class), f[10], "slot1 class");
			check_value(pair_info.slot1.target, f[11], "slot1 target");
		end
		if (f[9][0])
		begin
			check_value(pair_info.slot2.pc, f[7] + 64'd4, "slot2 pc");
			check_value(64'(pair_info.slot2.op_class), f[12], "slot2 class");
			check_value(pair_info.slot2.target, f[13], "slot2 target");
		end
		#1;
	endtask

	task automatic run_line(input string line);
		logic [63:0]     f [14];
		logic [8*32-1:0] name;
		int              n;
		case (line.getc(0))
			"T":
			begin
				n = $sscanf(line, "T %s", name);
				close_test();
				test_name   = name;
				in_test     = 1'b1;
				test_errors = 0;
				tests_run++;
			end
			"W":
			begin
				n = $sscanf(line, "W %h %h", f[0], f[1]);
				if (n == 2)
					write_word(f[0], f[1]);
			end
			"R":
			begin
				n = $sscanf(line, "R %h %h", f[0], f[1]);
				if (n == 2)
					read_word(f[0], f[1]);
			end
			"F":
			begin
				n = $sscanf(line, "F %h %h %h %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1],
					f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
				if (n == 14)
					fetch_step(f);
				else
					n = -1;
			end
			default: n = -1;
		endcase
		if (n < 0 || (line.getc(0) != "T" && line.getc(0) != "F" && n != 2))
		begin
			$display("test file step could not be read: %0s", line);
			errors++;
			test_errors++;
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////
	initial
	begin
		int    fd;
		int    cycles;
		int    lines;
		string line;
		stalls        = '0;
		branch_taken  = 1'b0;
		branch_target = '0;
		fetch_enable  = 1'b0;
		data_req      = '0;
		errors        = 0;
		checks        = 0;
		tests_run     = 0;
		test_errors   = 0;
		in_test       = 1'b0;
		test_name     = '0;
		cycles        = 0;
		lines         = 0;

		while (reset !== 1'b0 && cycles < 20)	// bounded wait for reset release
		begin
			@(posedge clock);
			cycles++;
		end
		if (reset !== 1'b0)
			$display("reset was never released");
		#2;

		fd = $fopen("dv/fetch_tests.txt", "r");
		if (fd == 0)
			$display("could not open the test file dv/fetch_tests.txt");
		while (fd != 0 && !reset && !$feof(fd) && lines < 1000)
		begin
			lines++;
			if ($fgets(line, fd) > 1 && line.getc(0) != "#")	// skip comments and blanks
				run_line(line);
		end
		if (fd != 0)
			$fclose(fd);
		close_test();

		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (fd != 0 && !reset && errors == 0 && checks > 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: hw/fetch_top.sv
/*
 * fetch subsystem top
 */

`timescale 1ns/1ns

module fetch_top
	import fetch_pkg::*;
#(
	parameter int mem_words = 256	// shared memory depth, 64-bit words
)(
	input  logic        clock,
	input  logic        reset,
	input  stall_t      stalls,			// rs, rob, rat back-pressure
	input  logic        branch_taken,
	input  logic [63:0] branch_target,
	input  logic        fetch_enable,
	input  data_req_t   data_req,		// data side of the shared memory
	output logic [63:0] data_rdata,
	output logic [63:0] fetch_addr,
	output pair_info_t  pair_info		// one cycle after fetch_addr
);

	logic [63:0] fetch_data;
	logic        fetch_valid;
	logic        hazard_stall;
	fetch_pair_t fetch_pair;
	logic [63:0] slot2_pc;		// second instruction of the word

	//////////////////////////////////////////////////
	// memory and address stage
	//////////////////////////////////////////////////
	shared_memory #(
		.mem_words (mem_words)
	) i_shared_memory (
		.clock        (clock),
		.fetch_addr   (fetch_addr),
		.data_req     (data_req),
		.fetch_data   (fetch_data),
		.fetch_valid  (fetch_valid),
		.hazard_stall (hazard_stall),
		.data_rdata   (data_rdata)
	);

	fetch_pc i_fetch_pc (
		.clock         (clock),
		.reset         (reset),
		.stalls        (stalls),
		.hazard_stall  (hazard_stall),
		.fetch_enable  (fetch_enable),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.fetch_data    (fetch_data),
		.fetch_valid   (fetch_valid),
		.fetch_addr    (fetch_addr),
		.fetch_pair    (fetch_pair)
	);

	//////////////////////////////////////////////////
	// predecode, one per slot
	//////////////////////////////////////////////////
	assign slot2_pc = fetch_pair.pc + 64'd4;

	predecode i_predecode_slot1 (
		.valid (fetch_pair.valid1),
		.pc    (fetch_pair.pc),
		.inst  (fetch_pair.inst1),
		.info  (pair_info.slot1)
	);

	predecode i_predecode_slot2 (
		.valid (fetch_pair.valid2),
		.pc    (slot2_pc),
		.inst  (fetch_pair.inst2),
		.info  (pair_info.slot2)
	);

endmodule

// File: hw/shared_memory.sv
/*
 * shared instruction and data memory
 */

`timescale 1ns/1ns

module shared_memory
	import fetch_pkg::*;
#(
	parameter int mem_words = 256	// depth in 64-bit words
)(
	input  logic        clock,
	input  logic [63:0] fetch_addr,
	input  data_req_t   data_req,
	output logic [63:0] fetch_data,
	output logic        fetch_valid,
	output logic        hazard_stall,	// data side took the port
	output logic [63:0] data_rdata
);

	localparam int idx_w = (mem_words > 1) ? $clog2(mem_words) : 1;

	logic [63:0] mem [mem_words];	// one array, one port

	logic [60:0] fetch_word;	// word address, byte offset dropped
	logic [60:0] data_word;
	logic        fetch_in_range;
	logic        data_in_range;
	logic        data_write;

	assign fetch_word = fetch_addr[63:3];
	assign data_word  = data_req.addr[63:3];

	assign fetch_in_range = fetch_word < 61'(mem_words);
	assign data_in_range  = data_word < 61'(mem_words);

	//////////////////////////////////////////////////
	// port arbitration, data wins
	//////////////////////////////////////////////////
	assign hazard_stall = data_req.valid;
	assign fetch_valid  = !hazard_stall && fetch_in_range;

	// no fetch read while data owns the port
	assign fetch_data = fetch_valid ? mem[fetch_word[idx_w-1:0]] : '0;

	always_comb
	begin
		if (data_req.valid && !data_req.write && data_in_range)
			data_rdata = mem[data_word[idx_w-1:0]];	// same cycle read
		else
			data_rdata = '0;
	end

	//////////////////////////////////////////////////
	// writes land at the edge
	//////////////////////////////////////////////////
	assign data_write = data_req.valid && data_req.write && data_in_range;

	always_ff @(posedge clock)
	begin
		if (data_write)
			mem[data_word[idx_w-1:0]] <= data_req.wdata;
	end

endmodule

// File: hw/fetch/predecode.sv
/*
 * slot predecode
 */

`timescale 1ns/1ns

module predecode
	import isa_pkg::*;
	import fetch_pkg::*;
(
	input  logic        valid,
	input  logic [63:0] pc,		// address of this instruction
	input  inst_t       inst,
	output slot_info_t  info
);

	op_class_e   op_class;
	logic [63:0] b_imm;		// conditional branch offset
	logic [63:0] j_imm;		// jal offset
	logic [63:0] target;

	//////////////////////////////////////////////////
	// immediates, both from the branch view
	//////////////////////////////////////////////////

	// b-type: imm[12|10:5] ... imm[4:1|11]
	assign b_imm = {{51{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
		inst.b.imm10_5, inst.b.imm4_1, 1'b0};

	// j-type packs imm[19:12] where rs1/funct3 sit, imm[11] at rs2 bit 0
	assign j_imm = {{43{inst.b.imm12}}, inst.b.imm12, inst.b.rs1, inst.b.funct3,
		inst.b.rs2[0], inst.b.imm10_5, inst.b.rs2[4:1], 1'b0};

	// class from the register view opcode
	always_comb
	begin
		case (inst.r.opcode)
			opc_op,
			opc_op_imm: op_class = class_alu;
			opc_load:   op_class = class_load;
			opc_store:  op_class = class_store;
			opc_branch: op_class = class_branch;
			opc_jal:    op_class = class_jump;
			default:    op_class = class_unknown;
		endcase
	end

	always_comb
	begin
		case (op_class)
			class_branch: target = pc + b_imm;	// static taken target
			class_jump:   target = pc + j_imm;
			default:      target = pc + 64'd4;	// fall through
		endcase
	end

	assign info.valid    = valid;
	assign info.pc       = pc;
	assign info.op_class = op_class;
	assign info.target   = target;

endmodule

// File: hw/fetch/fetch_pc.sv
/*
 * fetch address register
 */

`timescale 1ns/1ns

module fetch_pc
	import fetch_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  stall_t      stalls,			// core back-pressure
	input  logic        hazard_stall,	// data side holds the memory
	input  logic        fetch_enable,
	input  logic        branch_taken,	// resolved taken branch from a functional unit
	input  logic [63:0] branch_target,
	input  logic [63:0] fetch_data,		// word read at fetch_addr
	input  logic        fetch_valid,
	output logic [63:0] fetch_addr,		// always 8-byte aligned
	output fetch_pair_t fetch_pair
);

	logic [63:0] pc_reg;		// address being fetched
	logic [63:0] next_pc;
	logic        hold;			// any reason to not advance
	logic        next_valid;	// both slots share one valid decision

	assign fetch_addr = {pc_reg[63:3], 3'b000};

	assign hold = stalls.rs || stalls.rob || stalls.rat
		|| hazard_stall
		|| !fetch_enable
		|| !fetch_valid;

	//////////////////////////////////////////////////
	// next address, taken branch beats every stall
	//////////////////////////////////////////////////
	always_comb
	begin
		if (branch_taken)
		begin
			next_pc    = branch_target;	// redirect, never lost to a stall
			next_valid = 1'b0;			// squash the word read this cycle
		end
		else if (hold)
		begin
			next_pc    = pc_reg;
			next_valid = 1'b0;
		end
		else
		begin
			next_pc    = pc_reg + 64'd8;	// two instructions per word
			next_valid = 1'b1;
		end
	end

	// payload follows the address, the valids say whether it counts
	always_ff @(posedge clock)
	begin
		fetch_pair.pc    <= fetch_addr;
		fetch_pair.inst1 <= fetch_data[63:32];	// lower address goes first
		fetch_pair.inst2 <= fetch_data[31:0];
		if (reset)
		begin
			pc_reg            <= '0;
			fetch_pair.valid1 <= 1'b0;
			fetch_pair.valid2 <= 1'b0;
		end
		else
		begin
			pc_reg            <= next_pc;
			fetch_pair.valid1 <= next_valid;
			fetch_pair.valid2 <= next_valid;
		end
	end

endmodule

// File: common/fetch_pkg.sv
/*
 * fetch side structs
 */

package fetch_pkg;

	import isa_pkg::*;

	//////////////////////////////////////////////////
	// back-pressure from the out of order core
	//////////////////////////////////////////////////
	typedef struct packed {
		logic rs;	// reservation station full
		logic rob;	// reorder buffer full
		logic rat;	// rename free list empty
	} stall_t;

	// registered pair leaving the fetch address stage
	typedef struct packed {
		logic [63:0] pc;		// aligned address of the word
		inst_t       inst1;		// word bits 63:32
		inst_t       inst2;		// word bits 31:0
		logic        valid1;
		logic        valid2;
	} fetch_pair_t;

	//////////////////////////////////////////////////
	// data side access to the shared memory
	//////////////////////////////////////////////////
	typedef struct packed {
		logic        valid;	// data side owns the array this cycle
		logic        write;	// 1 write, 0 read
		logic [63:0] addr;	// byte address, bits 2:0 ignored
		logic [63:0] wdata;
	} data_req_t;

	// predecode result for one slot
	typedef struct packed {
		logic        valid;
		logic [63:0] pc;
		op_class_e   op_class;
		logic [63:0] target;	// static target or pc + 4
	} slot_info_t;

	typedef struct packed {
		slot_info_t slot1;	// older instruction
		slot_info_t slot2;
	} pair_info_t;

endpackage

// File: common/isa_pkg.sv
/*
 * instruction set definitions
 */

package isa_pkg;

	//////////////////////////////////////////////////
	// major opcodes, bits 6:0 of every instruction
	//////////////////////////////////////////////////
	typedef enum logic [6:0] {
		opc_op     = 7'b0110011,	// register-register alu
		opc_op_imm = 7'b0010011,	// register-immediate alu
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_branch = 7'b1100011,	// conditional branch
		opc_jal    = 7'b1101111		// jump and link
	} opcode_e;

	// coarse operation class handed to dispatch
	typedef enum logic [2:0] {
		class_alu     = 3'd0,
		class_load    = 3'd1,
		class_store   = 3'd2,
		class_branch  = 3'd3,
		class_jump    = 3'd4,
		class_unknown = 3'd7	// opcode not recognized
	} op_class_e;

	//////////////////////////////////////////////////
	// two views of one 32-bit instruction word
	//////////////////////////////////////////////////
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_format_t;

	// branch view, immediate split around the register fields
	typedef struct packed {
		logic       imm12;		// sign bit
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_format_t;

	typedef union packed {
		r_format_t r;	// classification
		b_format_t b;	// target immediate
	} inst_t;

endpackage
